//--- verilog/ifetch_defs.svh
// Instruction fetch sizing
// Buffer depth, outstanding limit and counter widths shared by
// the prefetcher, the OBI adapter and the fetch buffer

`ifndef IFETCH_DEFS_SVH
`define IFETCH_DEFS_SVH

////////////////////////////////////////////////////////////
// Buffer and credits
////////////////////////////////////////////////////////////

// Fetch buffer entries, also the initial credit count
`define IFETCH_FIFO_DEPTH 4

// Grant parity FIFO size in the adapter
`define IFETCH_MAX_OUTSTANDING `IFETCH_FIFO_DEPTH

// Credit and outstanding counters, must hold the depth itself
`define IFETCH_CNT_W 3

`endif

//--- verilog/ifetch_pkg.sv
// Instruction fetch types
// OBI address and read phase payloads, the fetch buffer entry
// and the adapter FSM states

package ifetch_pkg;

  ////////////////////////////////////////////////////////////
  // OBI payloads
  ////////////////////////////////////////////////////////////

  // Address phase payload
  typedef struct packed {
    logic [31:0] addr;
    logic [2:0]  prot;
    logic [1:0]  memtype;
    logic        dbg;
    logic [11:0] achk;
  } obi_req_t;

  // Read phase payload
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
    logic [4:0]  rchk;
  } obi_resp_t;

  // One fetch buffer entry handed to decode
  typedef struct packed {
    logic [31:0] rdata;
    logic        bus_err;
    logic        parity_err;
    logic        rchk_err;
  } fetch_entry_t;

  // Adapter address phase FSM
  typedef enum logic {
    TRANSPARENT,
    REGISTERED
  } obi_a_state_e;

  // Registered request after reset
  localparam obi_req_t OBI_REQ_RESET_VAL = '0;

endpackage

//--- verilog/ifetch_prefetcher.sv
// Sequential instruction prefetcher
// Walks word addresses from the boot address and issues one fetch
// per credit; credits come back from the fetch buffer on each pop

`timescale 1ns/10ps
`include "ifetch_defs.svh"

module ifetch_prefetcher (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                fetch_en_i,
  input  logic [31:0]         boot_addr_i,
  input  logic                credit_return_i,
  output logic                trans_valid_o,
  input  logic                trans_ready_i,
  output ifetch_pkg::obi_req_t trans_o
);

  // Full credit count, one per buffer slot
  localparam logic [`IFETCH_CNT_W-1:0] CREDIT_INIT = `IFETCH_FIFO_DEPTH;

  logic [31:0]              addr_q;
  logic [`IFETCH_CNT_W-1:0] credit_q;
  logic                     take;

  // Fetch accepted by the adapter
  assign take = trans_valid_o && trans_ready_i;

  // Only request while a buffer slot is guaranteed
  assign trans_valid_o = fetch_en_i && (credit_q != '0);

  // Machine mode instruction fetch, achk filled in by the adapter
  always_comb begin
    trans_o         = ifetch_pkg::OBI_REQ_RESET_VAL;
    trans_o.addr    = addr_q;
    trans_o.prot    = 3'b110;
    trans_o.memtype = 2'b00;
    trans_o.dbg     = 1'b0;
  end

  // Next fetch address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (!fetch_en_i) begin
      // Track boot address until fetching starts
      addr_q <= boot_addr_i;
    end else if (take) begin
      addr_q <= addr_q + 32'd4;
    end
  end

  // Credit counter, take and return may hit in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_q <= CREDIT_INIT;
    end else if (take && !credit_return_i) begin
      credit_q <= credit_q - 1'b1;
    end else if (!take && credit_return_i) begin
      credit_q <= credit_q + 1'b1;
    end
  end

endmodule

//--- verilog/ifetch_obi_adapter.sv
// OBI instruction bus adapter
// Maps fetch requests onto the OBI A channel, holding the address
// phase stable while gnt is withheld and inserting achk
// R channel responses pass straight through as fetch entries,
// tagged with gnt/rvalid parity and rchk errors

`timescale 1ns/10ps
`include "ifetch_defs.svh"

module ifetch_obi_adapter (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     trans_valid_i,
  output logic                     trans_ready_o,
  input  ifetch_pkg::obi_req_t     trans_i,
  output logic                     resp_valid_o,
  output ifetch_pkg::fetch_entry_t resp_o,
  output logic                     integrity_err_o,
  output logic                     obi_req_o,
  output logic                     obi_reqpar_o,
  output ifetch_pkg::obi_req_t     obi_a_o,
  input  logic                     obi_gnt_i,
  input  logic                     obi_gntpar_i,
  input  logic                     obi_rvalid_i,
  input  logic                     obi_rvalidpar_i,
  input  ifetch_pkg::obi_resp_t    obi_r_i
);

  ifetch_pkg::obi_a_state_e state_q, next_state;
  ifetch_pkg::obi_req_t     obi_a_q;
  logic [11:0]              achk;
  logic [4:0]               rchk_exp;
  // Bit 0 stays low so cnt_q indexes the oldest entry directly
  logic [`IFETCH_MAX_OUTSTANDING:0] par_fifo_q;
  logic [`IFETCH_CNT_W-1:0] cnt_q;
  logic                     accept;
  logic                     gntpar_err;
  logic                     gntpar_err_q;
  logic                     rvalidpar_err;
  logic                     rchk_err;

  ////////////////////////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////////////////////////

  // Odd parity per field group, top bit first
  assign achk = {~^8'h00, ~^8'h00, ~^8'h00, ~^8'h00,
                 ~^6'h00,
                 ~^trans_i.dbg,
                 ~^{4'b1111, 1'b0},
                 ~^{trans_i.prot, trans_i.memtype},
                 ~^trans_i.addr[31:24],
                 ~^trans_i.addr[23:16],
                 ~^trans_i.addr[15:8],
                 ~^{trans_i.addr[7:2], 2'b00}};

  always_comb begin
    next_state = state_q;
    case (state_q)
      // Ungranted request, freeze the address phase
      ifetch_pkg::TRANSPARENT: if (obi_req_o && !obi_gnt_i) next_state = ifetch_pkg::REGISTERED;
      ifetch_pkg::REGISTERED:  if (obi_gnt_i) next_state = ifetch_pkg::TRANSPARENT;
      default:                 next_state = ifetch_pkg::TRANSPARENT;
    endcase
  end

  always_comb begin
    if (state_q == ifetch_pkg::TRANSPARENT) begin
      obi_req_o    = trans_valid_i;
      obi_a_o      = trans_i;
      obi_a_o.achk = achk;
    end else begin
      // Request never retracted before gnt
      obi_req_o = 1'b1;
      obi_a_o   = obi_a_q;
    end
  end

  assign obi_reqpar_o  = ~obi_req_o;
  assign trans_ready_o = (state_q == ifetch_pkg::TRANSPARENT);
  assign accept        = obi_req_o && obi_gnt_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ifetch_pkg::TRANSPARENT;
      obi_a_q <= ifetch_pkg::OBI_REQ_RESET_VAL;
    end else begin
      state_q <= next_state;
      if ((state_q == ifetch_pkg::TRANSPARENT) && (next_state == ifetch_pkg::REGISTERED)) begin
        obi_a_q <= obi_a_o;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Grant parity tracking
  ////////////////////////////////////////////////////////////

  // Only meaningful while an address phase is open
  assign gntpar_err = obi_req_o && (obi_gnt_i == obi_gntpar_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gntpar_err_q <= 1'b0;
      par_fifo_q   <= '0;
      cnt_q        <= '0;
    end else begin
      // Sticky over waited cycles, cleared on gnt
      if (obi_req_o) gntpar_err_q <= obi_gnt_i ? 1'b0 : (gntpar_err || gntpar_err_q);
      // Newest error enters at bit 1
      if (accept) begin
        par_fifo_q <= {par_fifo_q[`IFETCH_MAX_OUTSTANDING-1:1], gntpar_err || gntpar_err_q, 1'b0};
      end
      if (accept && !obi_rvalid_i) cnt_q <= cnt_q + 1'b1;
      else if (!accept && obi_rvalid_i) cnt_q <= cnt_q - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response checks
  ////////////////////////////////////////////////////////////

  assign rvalidpar_err = (obi_rvalid_i == obi_rvalidpar_i);
  assign rchk_exp      = {~^obi_r_i.err, ~^obi_r_i.rdata[31:24], ~^obi_r_i.rdata[23:16],
                          ~^obi_r_i.rdata[15:8], ~^obi_r_i.rdata[7:0]};
  assign rchk_err      = obi_rvalid_i && (obi_r_i.rchk != rchk_exp);

  // Consumer has space for every response thanks to credits
  assign resp_valid_o      = obi_rvalid_i;
  assign resp_o.rdata      = obi_r_i.rdata;
  assign resp_o.bus_err    = obi_r_i.err;
  assign resp_o.parity_err = rvalidpar_err || par_fifo_q[cnt_q];
  assign resp_o.rchk_err   = rchk_err;

  assign integrity_err_o = gntpar_err || rvalidpar_err || rchk_err;

endmodule

//--- verilog/ifetch_resp_buffer.sv
// In-order fetch buffer
// Stores adapter responses in a circular buffer and presents the
// head to decode from a register; each pop returns one credit

`timescale 1ns/10ps
`include "ifetch_defs.svh"

module ifetch_resp_buffer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     push_i,
  input  ifetch_pkg::fetch_entry_t push_data_i,
  output logic                     instr_valid_o,
  input  logic                     instr_ready_i,
  output ifetch_pkg::fetch_entry_t instr_o,
  output logic                     credit_return_o
);

  localparam int DEPTH = `IFETCH_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = `IFETCH_CNT_W;

  ifetch_pkg::fetch_entry_t mem_q [DEPTH];
  logic [PTR_W-1:0] wptr_q, rptr_q, rptr_nxt;
  logic [CNT_W-1:0] count_q, count_left;
  logic             pop;

  assign pop        = instr_valid_o && instr_ready_i;
  assign rptr_nxt   = rptr_q + PTR_W'(pop);
  // Entries left once this cycle's pop is taken
  assign count_left = count_q - CNT_W'(pop);

  // Head register mirrors mem at rptr and valid follows count
  assign instr_valid_o = (count_q != '0);

  // Entry storage
  always_ff @(posedge clk) begin
    if (push_i) mem_q[wptr_q] <= push_data_i;
  end

  // Head entry for the next cycle with bypass when the buffer drains
  always_ff @(posedge clk) begin
    if (count_left == '0) begin
      instr_o <= push_data_i;
    end else begin
      instr_o <= mem_q[rptr_nxt];
    end
  end

  ////////////////////////////////////////////////////////////
  // Pointers, count and credits
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr_q          <= '0;
      rptr_q          <= '0;
      count_q         <= '0;
      credit_return_o <= 1'b0;
    end else begin
      if (push_i) wptr_q <= wptr_q + 1'b1;
      rptr_q          <= rptr_nxt;
      count_q         <= count_left + CNT_W'(push_i);
      // One credit back the cycle after each pop
      credit_return_o <= pop;
    end
  end

endmodule

//--- verilog/ifetch_top.sv
// Instruction fetch unit
// Prefetcher, OBI adapter and fetch buffer between the instruction
// bus and decode, with credit flow control closing the loop

`timescale 1ns/10ps

module ifetch_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     fetch_en_i,
  input  logic [31:0]              boot_addr_i,
  output logic                     instr_valid_o,
  input  logic                     instr_ready_i,
  output ifetch_pkg::fetch_entry_t instr_o,
  output logic                     integrity_err_o,
  output logic                     obi_req_o,
  output logic                     obi_reqpar_o,
  output ifetch_pkg::obi_req_t     obi_a_o,
  input  logic                     obi_gnt_i,
  input  logic                     obi_gntpar_i,
  input  logic                     obi_rvalid_i,
  input  logic                     obi_rvalidpar_i,
  input  ifetch_pkg::obi_resp_t    obi_r_i
);

  // Prefetcher to adapter
  logic                     trans_valid;
  logic                     trans_ready;
  ifetch_pkg::obi_req_t     trans;
  // Adapter to buffer
  logic                     resp_valid;
  ifetch_pkg::fetch_entry_t resp;
  // Buffer to prefetcher
  logic                     credit_return;

  ifetch_prefetcher prefetcher_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .fetch_en_i      (fetch_en_i),
    .boot_addr_i     (boot_addr_i),
    .credit_return_i (credit_return),
    .trans_valid_o   (trans_valid),
    .trans_ready_i   (trans_ready),
    .trans_o         (trans)
  );

  ifetch_obi_adapter adapter_i (
    .clk (clk), .rst_n (rst_n),
    .trans_valid_i (trans_valid), .trans_ready_o (trans_ready), .trans_i (trans),
    .resp_valid_o (resp_valid), .resp_o (resp), .integrity_err_o (integrity_err_o),
    .obi_req_o (obi_req_o), .obi_reqpar_o (obi_reqpar_o), .obi_a_o (obi_a_o),
    .obi_gnt_i (obi_gnt_i), .obi_gntpar_i (obi_gntpar_i),
    .obi_rvalid_i (obi_rvalid_i), .obi_rvalidpar_i (obi_rvalidpar_i), .obi_r_i (obi_r_i)
  );

  ifetch_resp_buffer buffer_i (
    .clk (clk), .rst_n (rst_n),
    .push_i (resp_valid), .push_data_i (resp),
    .instr_valid_o (instr_valid_o), .instr_ready_i (instr_ready_i), .instr_o (instr_o),
    .credit_return_o (credit_return)
  );

endmodule

//--- verif/obi_mem_model.sv
// OBI instruction memory model
// Grants with random stalls and answers in order, at least one cycle
// after each grant. Read data is the address XOR a fixed pattern.
// Faults are injected on chosen transaction numbers

`timescale 1ns/10ps

module obi_mem_model #(
  parameter logic [31:0] DATA_XOR = 32'h0,
  parameter int          INJ_GNT  = -1,
  parameter int          INJ_WAIT = -1,
  parameter int          INJ_RVP  = -1,
  parameter int          INJ_RCHK = -1,
  parameter int          INJ_ERR  = -1
) (
  input  logic                  clk,
  input  logic                  stall_i,
  input  logic                  hold_i,
  input  logic                  obi_req_i,
  input  ifetch_pkg::obi_req_t  obi_a_i,
  output logic                  obi_gnt_o,
  output logic                  obi_gntpar_o,
  output logic                  obi_rvalid_o,
  output logic                  obi_rvalidpar_o,
  output ifetch_pkg::obi_resp_t obi_r_o
);

  int          gnt_cnt = 0;
  int          idx;
  logic        waited = 1'b0;
  logic        forced;
  // Granted transactions waiting for their response
  int          pend_idx[$];
  logic [31:0] pend_addr[$];

  // Odd parity per rdata byte, err parity on top
  function automatic logic [4:0] resp_checksum(input logic [31:0] data, input logic err);
    logic [4:0] chk;
    int         b;
    for (b = 0; b < 4; b++) begin
      chk[b] = ~^data[8*b +: 8];
    end
    chk[4] = ~err;
    return chk;
  endfunction

  initial begin
    obi_gnt_o       = 1'b0;
    obi_gntpar_o    = 1'b1;
    obi_rvalid_o    = 1'b0;
    obi_rvalidpar_o = 1'b1;
    obi_r_o         = '0;
  end

  always @(negedge clk) begin
    // Waited grant fault, gnt held off with bad parity for one requested cycle
    forced       = (gnt_cnt == INJ_WAIT) && !waited;
    obi_gnt_o    = !stall_i && !forced;
    obi_gntpar_o = (forced || (gnt_cnt == INJ_GNT)) ? obi_gnt_o : !obi_gnt_o;
    if ((pend_idx.size() != 0) && !hold_i) begin
      idx             = pend_idx.pop_front();
      obi_r_o.rdata   = pend_addr.pop_front() ^ DATA_XOR;
      obi_r_o.err     = (idx == INJ_ERR);
      obi_r_o.rchk    = resp_checksum(obi_r_o.rdata, obi_r_o.err);
      obi_r_o.rchk[0] = obi_r_o.rchk[0] ^ (idx == INJ_RCHK);
      obi_rvalid_o    = 1'b1;
      obi_rvalidpar_o = (idx == INJ_RVP);
    end else begin
      obi_rvalid_o    = 1'b0;
      obi_rvalidpar_o = 1'b1;
    end
    // Request is settled once every falling edge drive is in
    #1;
    if (obi_req_i && obi_gnt_o) begin
      pend_idx.push_back(gnt_cnt);
      pend_addr.push_back(obi_a_i.addr);
      gnt_cnt++;
      waited = 1'b0;
    end else if (obi_req_i && forced) begin
      waited = 1'b1;
    end
  end

endmodule

//--- verif/ifetch_tb.sv
// Instruction fetch testbench
// Runs ifetch_top against the OBI memory model with random grant
// stalls, response delays and decode back-pressure. Every popped
// instruction is checked against a reference built from its fetch index

`timescale 1ns/10ps
`include "ifetch_defs.svh"

module ifetch_tb;

  localparam logic [31:0] BOOT_ADDR = 32'h1c00_0080;
  localparam logic [31:0] DATA_XOR  = 32'h5a3c_96e1;
  localparam int          DEPTH     = `IFETCH_FIFO_DEPTH;
  localparam int          LIMIT     = 4000;
  // Injected fault per transaction number
  localparam int INJ_GNT  = 86;
  localparam int INJ_WAIT = 92;
  localparam int INJ_RVP  = 100;
  localparam int INJ_RCHK = 118;
  localparam int INJ_ERR  = 126;

  logic                     clk = 1'b0;
  logic                     rst_n, fetch_en, instr_valid, instr_ready, integrity_err;
  logic [31:0]              boot_addr;
  ifetch_pkg::fetch_entry_t instr;
  logic                     obi_req, obi_reqpar, obi_gnt, obi_gntpar;
  logic                     obi_rvalid, obi_rvalidpar;
  ifetch_pkg::obi_req_t     obi_a, held_a;
  ifetch_pkg::obi_resp_t    obi_r;

  // Stimulus controls drawn from the LFSR on the rising edge
  logic [31:0] lfsr_q = 32'd66512;
  logic        stall_en = 1'b0;
  logic [1:0]  ready_mode = 2'd0;
  logic        stall = 1'b0;
  logic        hold = 1'b0;
  logic        ready_next = 1'b0;
  logic        held = 1'b0;
  logic        timed_out = 1'b0;

  // Scoreboard
  string test_name = "reset";
  int    grant_cnt = 0, pop_cnt = 0, integ_cnt = 0, integ_base = 0;
  int    check_cnt = 0, err_cnt = 0, check_base = 0, err_base = 0;
  int    test_cnt = 0, fail_cnt = 0;

  ifetch_top dut_i (
    .clk (clk), .rst_n (rst_n), .fetch_en_i (fetch_en), .boot_addr_i (boot_addr),
    .instr_valid_o (instr_valid), .instr_ready_i (instr_ready), .instr_o (instr),
    .integrity_err_o (integrity_err), .obi_req_o (obi_req), .obi_reqpar_o (obi_reqpar),
    .obi_a_o (obi_a), .obi_gnt_i (obi_gnt), .obi_gntpar_i (obi_gntpar),
    .obi_rvalid_i (obi_rvalid), .obi_rvalidpar_i (obi_rvalidpar), .obi_r_i (obi_r)
  );

  obi_mem_model #(
    .DATA_XOR (DATA_XOR), .INJ_GNT (INJ_GNT), .INJ_WAIT (INJ_WAIT),
    .INJ_RVP (INJ_RVP), .INJ_RCHK (INJ_RCHK), .INJ_ERR (INJ_ERR)
  ) mem_i (
    .clk (clk), .stall_i (stall), .hold_i (hold), .obi_req_i (obi_req), .obi_a_i (obi_a),
    .obi_gnt_o (obi_gnt), .obi_gntpar_o (obi_gntpar), .obi_rvalid_o (obi_rvalid),
    .obi_rvalidpar_o (obi_rvalidpar), .obi_r_o (obi_r)
  );

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] v;
    int         i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v      = {v[6:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // achk per field group with the wdata, atop and be/we groups fixed at one
  function automatic logic [11:0] addr_checksum(input ifetch_pkg::obi_req_t a);
    logic [11:0] c;
    c[11:7] = 5'b11111;
    c[6]    = ~a.dbg;
    c[5]    = 1'b1;
    c[4]    = ~^{a.prot, a.memtype};
    c[3]    = ~^a.addr[31:24];
    c[2]    = ~^a.addr[23:16];
    c[1]    = ~^a.addr[15:8];
    c[0]    = ~^a.addr[7:2];
    return c;
  endfunction

  // Expected instruction for fetch number n
  function automatic ifetch_pkg::fetch_entry_t expected_entry(input int n);
    ifetch_pkg::fetch_entry_t e;
    e.rdata      = (BOOT_ADDR + 32'(4 * n)) ^ DATA_XOR;
    e.bus_err    = (n == INJ_ERR);
    e.parity_err = (n == INJ_GNT) || (n == INJ_WAIT) || (n == INJ_RVP);
    e.rchk_err   = (n == INJ_RCHK);
    return e;
  endfunction

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    check_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("error %s %s: expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  // Kind 0 counts popped instructions and kind 1 granted but unpopped fetches
  task automatic wait_for(input int kind, input int target);
    int cycles;
    cycles = 0;
    if (!timed_out) begin
      while (((kind == 0) ? pop_cnt : grant_cnt - pop_cnt) < target && cycles < LIMIT) begin
        @(negedge clk);
        cycles++;
      end
      if (((kind == 0) ? pop_cnt : grant_cnt - pop_cnt) < target) begin
        timed_out = 1'b1;
        $display("timeout in %s: count still below %0d after %0d cycles",
                 test_name, target, cycles);
      end
    end
  endtask

  task automatic start_test(input string name);
    test_name  = name;
    check_base = check_cnt;
    err_base   = err_cnt;
  endtask

  task automatic finish_test();
    test_cnt++;
    if ((err_cnt != err_base) || timed_out) fail_cnt++;
    $display("test %s done: %0d checks, %0d errors",
             test_name, check_cnt - check_base, err_cnt - err_base);
  endtask

  initial begin
    forever begin
      #20 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    stall      = (take_bits(1) != 8'd0) && stall_en;
    hold       = (take_bits(1) != 8'd0) && stall_en;
    // Ready always high in mode 0, always low in mode 1 and 3 of 4 cycles in mode 2
    ready_next = (take_bits(2) != 8'd0) ? (ready_mode != 2'd1) : (ready_mode == 2'd0);
  end

  always @(negedge clk) begin
    instr_ready = ready_next;
  end

  // Bus monitor and comparator sampling just after the falling edge drives
  always @(negedge clk) begin
    #1;
    if (rst_n) begin
      check_value("reqpar", !obi_req, obi_reqpar);
      if (held) begin
        check_value("req held", 1, obi_req);
        check_value("addr phase held", held_a, obi_a);
      end
      if (obi_req) begin
        check_value("achk", addr_checksum(obi_a), obi_a.achk);
        // Fetch n reads boot address plus 4n as a machine mode instruction fetch
        check_value("addr phase", {BOOT_ADDR + 32'(4 * grant_cnt), 3'b110, 2'b00, 1'b0},
                    {obi_a.addr, obi_a.prot, obi_a.memtype, obi_a.dbg});
      end
      // Any parity error on the bus raises integrity_err in the same cycle
      if (obi_req && (obi_gnt == obi_gntpar)) begin
        check_value("integrity_err on gntpar", 1, integrity_err);
      end
      if (obi_rvalid == obi_rvalidpar) begin
        check_value("integrity_err on rvalidpar", 1, integrity_err);
      end
      held   = obi_req && !obi_gnt;
      held_a = obi_a;
      if (obi_req && obi_gnt) grant_cnt++;
      if (instr_valid && instr_ready) begin
        check_value("instr", expected_entry(pop_cnt), instr);
        pop_cnt++;
      end
      check_value("in flight over depth", 0, (grant_cnt - pop_cnt) > DEPTH);
      if (integrity_err) integ_cnt++;
    end
  end

  initial begin
    rst_n       = 1'b0;
    fetch_en    = 1'b0;
    boot_addr   = BOOT_ADDR;
    instr_ready = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    fetch_en = 1'b1;

    start_test("sequential_fetch");
    wait_for(0, 16);
    finish_test();

    start_test("stable_addr_phase");
    stall_en   = 1'b1;
    ready_mode = 2'd2;
    wait_for(0, 48);
    finish_test();

    // Decode stalls until credits run out and then drains
    start_test("back_pressure");
    ready_mode = 2'd1;
    wait_for(1, DEPTH);
    repeat (20) @(negedge clk);
    check_value("in flight at stop", DEPTH, grant_cnt - pop_cnt);
    ready_mode = 2'd2;
    wait_for(0, 80);
    finish_test();

    start_test("gnt_rvalid_parity");
    integ_base = integ_cnt;
    wait_for(0, 112);
    check_value("integrity_err seen", 1, integ_cnt > integ_base);
    finish_test();

    start_test("rchk_bus_err");
    wait_for(0, 144);
    finish_test();

    $display("%0d of %0d tests passed, %0d checks, %0d errors",
             test_cnt - fail_cnt, test_cnt, check_cnt, err_cnt);
    if ((err_cnt == 0) && (fail_cnt == 0) && !timed_out) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+verilog
verilog/ifetch_pkg.sv
verilog/ifetch_prefetcher.sv
verilog/ifetch_obi_adapter.sv
verilog/ifetch_resp_buffer.sv
verilog/ifetch_top.sv
verif/obi_mem_model.sv
verif/ifetch_tb.sv

//--- Makefile
# Verilator build and run for the instruction fetch testbench

VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = ifetch_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
